/* flist.f */
cpu_types_pkg.sv
dp_types_pkg.sv
register_file.sv
alu.sv
control_unit.sv
hazard_unit.sv
datapath.sv
datapath_checker.sv
datapath_scoreboard.sv
tb_datapath.sv

/* run_sim.sh */
#!/usr/bin/env bash
# builds and runs the testbench; exit status is nonzero unless the pass line is in sim.log
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -f flist.f --top-module tb_datapath \
    -o sim_datapath > build.log 2>&1 \
  && ./obj_dir/sim_datapath > sim.log 2>&1 ; \
grep -qx "NO ERRORS" sim.log 2>/dev/null \
  && echo "simulation passed" \
  || { echo "simulation failed, see build.log and sim.log"; exit 1; }

/* tb_datapath.sv */
/*
  testbench top for the pipelined core.
  four random programs of 48 instructions, each ending in HALT.
  data accesses use base register 0 and stay within 64 words.
  branch and jump targets always lie ahead, so every program ends.
*/
`timescale 1ns/100ps

module tb_datapath;

  localparam int PROG_LEN  = 48;
  localparam int MEM_WORDS = 64;
  localparam int NUM_TESTS = 4;
  localparam int LIMIT     = NUM_TESTS * PROG_LEN * 12 + 200;

  logic CLK = 1'b0;
  logic nRST = 1'b0;
  logic ihit = 1'b0;
  logic dhit = 1'b0;
  logic load_mem = 1'b0;
  int   wait_max = 0;
  int   iwait = 0;
  int   dwait = 0;
  int   mem_test = 0;
  int   cycles = 0;
  bit   verdict_given = 1'b0;

  cpu_types_pkg::word_t    imemaddr, imemload, dmemaddr, dmemstore, dmemload, wb_data;
  cpu_types_pkg::regbits_t wb_reg;
  logic imemREN, dmemREN, dmemWEN, halt, wb_wen;
  cpu_types_pkg::word_t imem [MEM_WORDS];
  cpu_types_pkg::word_t dmem [MEM_WORDS];

  always #4 CLK = ~CLK;

  datapath u_dut (.*);

  datapath_scoreboard u_sb (.*);

  bind datapath datapath_checker u_checker (.*);

  // memories answer combinationally, and only to an active read.
  assign imemload = imemREN ? imem[imemaddr[7:2]] : '0;
  assign dmemload = dmemREN ? dmem[dmemaddr[7:2]] : '0;

  function automatic cpu_types_pkg::word_t fill_word(input int t, input int i);
    return (32'(i) * 32'h9e37_79b9) + (32'(t) * 32'h0101_0101) + 32'(i);
  endfunction

  // each hit is followed by 0 to wait_max idle cycles.
  always @(posedge CLK) begin
    if (iwait == 0) begin
      ihit  <= 1'b1;
      iwait <= $urandom_range(0, wait_max);
    end else begin
      ihit  <= 1'b0;
      iwait <= iwait - 1;
    end
    if (dwait == 0) begin
      dhit  <= 1'b1;
      dwait <= $urandom_range(0, wait_max);
    end else begin
      dhit  <= 1'b0;
      dwait <= dwait - 1;
    end
    if (load_mem) begin
      for (int i = 0; i < MEM_WORDS; i++) begin
        dmem[i] <= fill_word(mem_test, i);
      end
    end else if (dmemWEN && dhit) begin
      dmem[dmemaddr[7:2]] <= dmemstore;
    end
  end

  always @(posedge CLK) begin
    cycles <= cycles + 1;
    if (cycles >= LIMIT) begin
      $display("timeout: run did not finish within %0d cycles", LIMIT);
      verdict_given = 1'b1;
      $display("ERRORS FOUND");
      $finish;
    end
  end

  function automatic cpu_types_pkg::word_t enc_r(input logic [5:0] fn,
      input cpu_types_pkg::regbits_t rs, input cpu_types_pkg::regbits_t rt,
      input cpu_types_pkg::regbits_t rd);
    return {6'h00, rs, rt, rd, 5'd0, fn};
  endfunction

  function automatic cpu_types_pkg::word_t enc_i(input logic [5:0] op,
      input cpu_types_pkg::regbits_t rs, input cpu_types_pkg::regbits_t rt,
      input logic [15:0] imm);
    return {op, rs, rt, imm};
  endfunction

  // a small register pool keeps dependencies close together.
  function automatic cpu_types_pkg::regbits_t rand_reg();
    return cpu_types_pkg::regbits_t'($urandom_range(0, 7));
  endfunction

  function automatic cpu_types_pkg::word_t random_instr(input int mode, input int i);
    int kind;
    int lim;
    int off;
    logic [5:0] fns [6];
    logic [5:0] iops [5];
    logic [5:0] cops [4];
    logic [5:0] op;
    fns  = '{6'h21, 6'h23, 6'h24, 6'h25, 6'h26, 6'h2a};
    iops = '{6'h09, 6'h0a, 6'h0c, 6'h0d, 6'h0f};
    cops = '{6'h04, 6'h05, 6'h02, 6'h03};
    kind = $urandom_range(0, 3);
    case (mode)
      0: kind = kind % 2;
      1: kind = (kind == 3) ? 2 : kind;
      2: kind = (kind == 2) ? 3 : kind;
      default: ;
    endcase
    case (kind)
      0: return enc_r(fns[$urandom_range(0, 5)], rand_reg(), rand_reg(), rand_reg());
      1: begin
        op = iops[$urandom_range(0, 4)];
        return enc_i(op, (op == 6'h0f) ? 5'd0 : rand_reg(), rand_reg(),
                     16'($urandom_range(0, 16'hffff)));
      end
      2: begin
        op = ($urandom_range(0, 1) == 1) ? 6'h23 : 6'h2b;
        return enc_i(op, 5'd0, rand_reg(), 16'(4 * $urandom_range(0, 63)));
      end
      default: begin
        lim = (46 - i < 3) ? 46 - i : 3;
        off = $urandom_range(0, lim);
        op = cops[$urandom_range(0, 3)];
        if (op == 6'h02 || op == 6'h03) return {op, 26'(i + 1 + off)};
        return enc_i(op, rand_reg(), rand_reg(), 16'(off));
      end
    endcase
  endfunction

  initial begin
    void'($urandom(39));
    for (int t = 0; t < NUM_TESTS; t++) begin
      @(posedge CLK);
      nRST <= 1'b0;
      load_mem <= 1'b1;
      mem_test <= t;
      // only the mixed test sees wait states.
      wait_max <= (t == 3) ? 2 : 0;
      for (int i = 0; i < MEM_WORDS; i++) begin
        if (i < PROG_LEN - 1) imem[i] = random_instr(t, i);
        else if (i == PROG_LEN - 1) imem[i] = {6'h3f, 26'd0};
        else imem[i] = '0;
        u_sb.prog[i] = imem[i];
        u_sb.dinit[i] = fill_word(t, i);
      end
      u_sb.start_test(t);
      repeat (2) @(posedge CLK);
      nRST <= 1'b1;
      load_mem <= 1'b0;
      while (!halt) @(posedge CLK);
      repeat (4) @(posedge CLK);
      u_sb.finish_test();
    end
    $display("tests passed %0d, failed %0d", u_sb.pass_cnt, u_sb.fail_cnt);
    verdict_given = 1'b1;
    if (u_sb.fail_cnt == 0 && u_sb.pass_cnt == NUM_TESTS) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

  // an assertion stop ends the run before any verdict.
  final begin
    if (!verdict_given) begin
      $display("run stopped early on a failed assertion");
      $display("ERRORS FOUND");
    end
  end

endmodule

/* datapath_scoreboard.sv */
/*
  in-order ISA model of the program, compared against the trace and store ports.
  a store counts as done on the cycle in which dhit accepts it.
  writes to register 0 still show on the trace with their computed value.
*/
`timescale 1ns/100ps

module datapath_scoreboard (
  input logic                    CLK,
  input logic                    nRST,
  input logic                    dhit,
  input logic                    halt,
  input logic                    wb_wen,
  input cpu_types_pkg::regbits_t wb_reg,
  input cpu_types_pkg::word_t    wb_data,
  input logic                    dmemWEN,
  input cpu_types_pkg::word_t    dmemaddr,
  input cpu_types_pkg::word_t    dmemstore
);

  cpu_types_pkg::word_t    prog [64];
  cpu_types_pkg::word_t    dinit [64];
  cpu_types_pkg::regbits_t exp_reg [$];
  cpu_types_pkg::word_t    exp_val [$];
  cpu_types_pkg::word_t    exp_addr [$];
  cpu_types_pkg::word_t    exp_data [$];
  cpu_types_pkg::regbits_t er;
  cpu_types_pkg::word_t    ev;
  cpu_types_pkg::word_t    ea;
  int n_writes, n_stores, test_id, test_err;
  int pass_cnt = 0;
  int fail_cnt = 0;
  bit active = 1'b0;

  task automatic run_model();
    cpu_types_pkg::word_t r [32];
    cpu_types_pkg::word_t m [64];
    cpu_types_pkg::word_t ins, a, b, res, imm_s, imm_z, addr;
    logic [5:0] op;
    cpu_types_pkg::regbits_t dst;
    int pc, npc, steps;
    bit wr, done;
    exp_reg.delete();
    exp_val.delete();
    exp_addr.delete();
    exp_data.delete();
    for (int i = 0; i < 32; i++) r[i] = '0;
    for (int i = 0; i < 64; i++) m[i] = dinit[i];
    pc = 0;
    steps = 0;
    done = 1'b0;
    while (!done && steps < 200) begin
      ins = prog[pc];
      op = ins[31:26];
      a = r[ins[25:21]];
      b = r[ins[20:16]];
      imm_s = {{16{ins[15]}}, ins[15:0]};
      imm_z = {16'h0, ins[15:0]};
      addr = a + imm_s;
      wr = 1'b1;
      dst = ins[20:16];
      npc = pc + 1;
      res = '0;
      case (op)
        6'h00: begin
          dst = ins[15:11];
          case (ins[5:0])
            6'h21: res = a + b;
            6'h23: res = a - b;
            6'h24: res = a & b;
            6'h25: res = a | b;
            6'h26: res = a ^ b;
            default: res = {31'd0, $signed(a) < $signed(b)};
          endcase
        end
        6'h09: res = a + imm_s;
        6'h0a: res = {31'd0, $signed(a) < $signed(imm_s)};
        6'h0c: res = a & imm_z;
        6'h0d: res = a | imm_z;
        6'h0f: res = {ins[15:0], 16'h0};
        6'h23: res = m[addr[7:2]];
        6'h2b: begin
          wr = 1'b0;
          m[addr[7:2]] = b;
          exp_addr.push_back(addr);
          exp_data.push_back(b);
        end
        6'h04, 6'h05: begin
          wr = 1'b0;
          if ((a == b) == (op == 6'h04)) npc = pc + 1 + $signed(imm_s);
        end
        6'h02: begin
          wr = 1'b0;
          npc = int'(ins[25:0]);
        end
        6'h03: begin
          dst = 5'd31;
          res = 32'((pc + 1) * 4);
          npc = int'(ins[25:0]);
        end
        default: begin
          wr = 1'b0;
          done = 1'b1;
        end
      endcase
      if (wr) begin
        exp_reg.push_back(dst);
        exp_val.push_back(res);
        if (dst != 0) r[dst] = res;
      end
      pc = npc;
      steps++;
    end
  endtask

  task automatic start_test(input int id);
    test_id = id;
    test_err = 0;
    n_writes = 0;
    n_stores = 0;
    run_model();
    active = 1'b1;
  endtask

  task automatic finish_test();
    active = 1'b0;
    if (!halt) begin
      $display("test %0d: halt is not high after the program ended", test_id);
      test_err++;
    end
    if (exp_reg.size() != 0 || exp_addr.size() != 0) begin
      $display("test %0d: %0d register writes and %0d stores never happened",
               test_id, exp_reg.size(), exp_addr.size());
      test_err++;
    end
    if (test_err == 0) pass_cnt++;
    else fail_cnt++;
    $display("test %0d %s: %0d writes, %0d stores, %0d errors", test_id,
             (test_err == 0) ? "passed" : "failed", n_writes, n_stores, test_err);
  endtask

  always @(posedge CLK) begin
    if (nRST && active) begin
      if (wb_wen) begin
        n_writes++;
        if (exp_reg.size() == 0) begin
          $display("FAILED at %0t: unexpected write r%0d=%h", $time, wb_reg, wb_data);
          test_err++;
        end else begin
          er = exp_reg.pop_front();
          ev = exp_val.pop_front();
          if (er != wb_reg || ev != wb_data) begin
            $display("FAILED at %0t: write %0d expected r%0d=%h, got r%0d=%h",
                     $time, n_writes, er, ev, wb_reg, wb_data);
            test_err++;
          end
        end
      end
      if (dmemWEN && dhit) begin
        n_stores++;
        if (exp_addr.size() == 0) begin
          $display("FAILED at %0t: unexpected store [%h]=%h", $time, dmemaddr, dmemstore);
          test_err++;
        end else begin
          ea = exp_addr.pop_front();
          ev = exp_data.pop_front();
          if (ea != dmemaddr || ev != dmemstore) begin
            $display("FAILED at %0t: store expected [%h]=%h, got [%h]=%h",
                     $time, ea, ev, dmemaddr, dmemstore);
            test_err++;
          end
        end
      end
    end
  end

endmodule

/* datapath_checker.sv */
/*
  assertions on the data port handshake and on halt.
  all checks are off while reset is low.
*/
`timescale 1ns/100ps

module datapath_checker (
  input logic                 CLK,
  input logic                 nRST,
  input logic                 dmemREN,
  input logic                 dmemWEN,
  input logic                 dhit,
  input logic                 halt,
  input cpu_types_pkg::word_t dmemaddr,
  input cpu_types_pkg::word_t dmemstore
);

  a_one_request: assert property (@(posedge CLK) disable iff (!nRST)
    !(dmemREN && dmemWEN))
    else $error("data read and write requested in the same cycle");

  // a waiting request keeps its address and data.
  a_hold_request: assert property (@(posedge CLK) disable iff (!nRST)
    ((dmemREN || dmemWEN) && !dhit) |=> ($stable(dmemaddr) && $stable(dmemstore)))
    else $error("data request changed before dhit");

  a_halt_sticky: assert property (@(posedge CLK) disable iff (!nRST)
    halt |=> halt)
    else $error("halt fell without reset");

endmodule

/* datapath.sv */
/*
  five-stage pipelined core for the MIPS subset.
  a taken branch or jump resolves in MEM and squashes three younger slots.
  a load followed by a dependent instruction costs one bubble.
  a low ihit, or a data access still waiting for dhit, freezes every stage.
  halt is sticky until reset; fetching stops once HALT is decoded.
*/
`timescale 1ns/100ps

module datapath (
  input  logic                    CLK,
  input  logic                    nRST,
  output cpu_types_pkg::word_t    imemaddr,
  output logic                    imemREN,
  input  cpu_types_pkg::word_t    imemload,
  input  logic                    ihit,
  output cpu_types_pkg::word_t    dmemaddr,
  output cpu_types_pkg::word_t    dmemstore,
  output logic                    dmemREN,
  output logic                    dmemWEN,
  input  cpu_types_pkg::word_t    dmemload,
  input  logic                    dhit,
  output logic                    halt,
  output logic                    wb_wen,
  output cpu_types_pkg::regbits_t wb_reg,
  output cpu_types_pkg::word_t    wb_data
);

  localparam int OPW = cpu_types_pkg::OPCODE_W;
  localparam int RW  = cpu_types_pkg::REG_W;
  localparam int IW  = cpu_types_pkg::IMM_W;

  logic advance, mem_wait, kill_fetch;
  logic pc_en, stall_id, flush_ex, branch_taken;
  dp_types_pkg::fwdsel_t fwd_a, fwd_b;
  cpu_types_pkg::word_t pc, pc4;

  // decode stage.
  cpu_types_pkg::word_t if_id_instr, if_id_pc4;
  cpu_types_pkg::regbits_t id_rs, id_rt, id_dest;
  cpu_types_pkg::word_t id_imm32, id_jaddr, rf_rdat1, rf_rdat2;
  dp_types_pkg::aluop_t cu_aluop;
  dp_types_pkg::alusrc_t cu_alusrc;
  dp_types_pkg::regsrc_t cu_regsrc;
  dp_types_pkg::regdst_t cu_regdst;
  dp_types_pkg::pcsrc_t cu_pcsrc;
  logic cu_regwen, cu_dren, cu_dwen, cu_extsel, cu_halt;

  // execute stage.
  logic id_ex_regwen, id_ex_dren, id_ex_dwen, id_ex_halt;
  dp_types_pkg::pcsrc_t id_ex_pcsrc;
  dp_types_pkg::aluop_t id_ex_aluop;
  dp_types_pkg::alusrc_t id_ex_alusrc;
  dp_types_pkg::regsrc_t id_ex_regsrc;
  cpu_types_pkg::word_t id_ex_pc4, id_ex_rdat1, id_ex_rdat2, id_ex_imm32, id_ex_jaddr;
  cpu_types_pkg::regbits_t id_ex_rs, id_ex_rt, id_ex_rd;
  cpu_types_pkg::word_t ex_a, ex_b, alu_b, alu_out, ex_result, ex_target;
  logic alu_zero;

  // memory and writeback stages.
  logic ex_mem_regwen, ex_mem_dren, ex_mem_dwen, ex_mem_halt, ex_mem_zero;
  dp_types_pkg::pcsrc_t ex_mem_pcsrc;
  cpu_types_pkg::word_t ex_mem_result, ex_mem_store, ex_mem_target;
  cpu_types_pkg::regbits_t ex_mem_rd;
  logic mem_done;
  cpu_types_pkg::word_t mem_hold;
  logic mem_wb_regwen, mem_wb_halt, mem_wb_is_load;
  cpu_types_pkg::word_t mem_wb_result, mem_wb_load;
  cpu_types_pkg::regbits_t mem_wb_rd;

  // global advance.
  assign mem_wait   = (dmemREN || dmemWEN) && !dhit;
  assign advance    = ihit && !mem_wait && !halt;
  assign kill_fetch = cu_halt || id_ex_halt || ex_mem_halt || mem_wb_halt || halt;

  // fetch.
  assign pc4      = pc + 32'd4;
  assign imemaddr = pc;
  assign imemREN  = 1'b1;

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      pc <= dp_types_pkg::PC_INIT;
    end else if (advance) begin
      if (branch_taken) begin
        pc <= ex_mem_target;
      end else if (pc_en && !kill_fetch) begin
        pc <= pc4;
      end
    end
  end

  // an all-zero word decodes as a no-op, so it serves as the bubble.
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      if_id_instr <= '0;
    end else if (advance) begin
      if (branch_taken) begin
        if_id_instr <= '0;
      end else if (!stall_id) begin
        if_id_instr <= kill_fetch ? '0 : imemload;
      end
    end
  end

  always_ff @(posedge CLK) begin
    if (advance && !stall_id) begin
      if_id_pc4 <= pc4;
    end
  end

  // decode.
  assign id_rs = if_id_instr[cpu_types_pkg::RS_LSB +: RW];
  assign id_rt = if_id_instr[cpu_types_pkg::RT_LSB +: RW];

  control_unit u_cu (
    .opcode (cpu_types_pkg::opcode_t'(if_id_instr[cpu_types_pkg::OP_LSB +: OPW])),
    .funct  (cpu_types_pkg::funct_t'(if_id_instr[cpu_types_pkg::FUNCT_W-1:0])),
    .aluop  (cu_aluop),
    .alusrc (cu_alusrc),
    .regsrc (cu_regsrc),
    .regdst (cu_regdst),
    .pcsrc  (cu_pcsrc),
    .regwen (cu_regwen),
    .dren   (cu_dren),
    .dwen   (cu_dwen),
    .extsel (cu_extsel),
    .halt   (cu_halt)
  );

  register_file u_rf (
    .CLK   (CLK),
    .nRST  (nRST),
    .wen   (wb_wen),
    .wsel  (mem_wb_rd),
    .wdat  (wb_data),
    .rsel1 (id_rs),
    .rsel2 (id_rt),
    .rdat1 (rf_rdat1),
    .rdat2 (rf_rdat2)
  );

  assign id_imm32 = {{(32 - IW){cu_extsel && if_id_instr[IW-1]}}, if_id_instr[IW-1:0]};
  assign id_jaddr = {if_id_pc4[31:28], if_id_instr[cpu_types_pkg::ADDR_W-1:0], 2'b00};

  always_comb begin
    case (cu_regdst)
      dp_types_pkg::REGDST_RD: id_dest = if_id_instr[cpu_types_pkg::RD_LSB +: RW];
      dp_types_pkg::REGDST_RT: id_dest = id_rt;
      dp_types_pkg::REGDST_RA: id_dest = RW'(cpu_types_pkg::REG_COUNT - 1);
      default:                 id_dest = '0;
    endcase
  end

  // ID/EX latch.
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      id_ex_regwen <= 1'b0;
      id_ex_dren   <= 1'b0;
      id_ex_dwen   <= 1'b0;
      id_ex_halt   <= 1'b0;
      id_ex_pcsrc  <= dp_types_pkg::PCSRC_SEQ;
    end else if (advance) begin
      id_ex_regwen <= cu_regwen && !flush_ex;
      id_ex_dren   <= cu_dren && !flush_ex;
      id_ex_dwen   <= cu_dwen && !flush_ex;
      id_ex_halt   <= cu_halt && !flush_ex;
      id_ex_pcsrc  <= flush_ex ? dp_types_pkg::PCSRC_SEQ : cu_pcsrc;
    end
  end

  always_ff @(posedge CLK) begin
    if (advance) begin
      id_ex_aluop  <= cu_aluop;
      id_ex_alusrc <= cu_alusrc;
      id_ex_regsrc <= cu_regsrc;
      id_ex_pc4    <= if_id_pc4;
      id_ex_rdat1  <= rf_rdat1;
      id_ex_rdat2  <= rf_rdat2;
      id_ex_imm32  <= id_imm32;
      id_ex_jaddr  <= id_jaddr;
      id_ex_rs     <= id_rs;
      id_ex_rt     <= id_rt;
      id_ex_rd     <= id_dest;
    end
  end

  // execute.
  always_comb begin
    case (fwd_a)
      dp_types_pkg::FWD_MEM: ex_a = ex_mem_result;
      dp_types_pkg::FWD_WB:  ex_a = wb_data;
      default:               ex_a = id_ex_rdat1;
    endcase
    case (fwd_b)
      dp_types_pkg::FWD_MEM: ex_b = ex_mem_result;
      dp_types_pkg::FWD_WB:  ex_b = wb_data;
      default:               ex_b = id_ex_rdat2;
    endcase
  end

  assign alu_b = (id_ex_alusrc == dp_types_pkg::ALUSRC_IMM) ? id_ex_imm32 : ex_b;

  alu u_alu (
    .aluop  (id_ex_aluop),
    .port_a (ex_a),
    .port_b (alu_b),
    .port_o (alu_out),
    .zero   (alu_zero)
  );

  // loads keep the ALU address here; the loaded word joins in writeback.
  always_comb begin
    case (id_ex_regsrc)
      dp_types_pkg::REGSRC_LUI: ex_result = {id_ex_imm32[IW-1:0], {(32 - IW){1'b0}}};
      dp_types_pkg::REGSRC_PC4: ex_result = id_ex_pc4;
      default:                  ex_result = alu_out;
    endcase
  end

  assign ex_target = (id_ex_pcsrc == dp_types_pkg::PCSRC_JUMP) ? id_ex_jaddr
                   : id_ex_pc4 + {id_ex_imm32[29:0], 2'b00};

  // EX/MEM latch.
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      ex_mem_regwen <= 1'b0;
      ex_mem_dren   <= 1'b0;
      ex_mem_dwen   <= 1'b0;
      ex_mem_halt   <= 1'b0;
      ex_mem_pcsrc  <= dp_types_pkg::PCSRC_SEQ;
    end else if (advance) begin
      ex_mem_regwen <= id_ex_regwen && !branch_taken;
      ex_mem_dren   <= id_ex_dren && !branch_taken;
      ex_mem_dwen   <= id_ex_dwen && !branch_taken;
      ex_mem_halt   <= id_ex_halt && !branch_taken;
      ex_mem_pcsrc  <= branch_taken ? dp_types_pkg::PCSRC_SEQ : id_ex_pcsrc;
    end
  end

  always_ff @(posedge CLK) begin
    if (advance) begin
      ex_mem_result <= ex_result;
      ex_mem_store  <= ex_b;
      ex_mem_target <= ex_target;
      ex_mem_zero   <= alu_zero;
      ex_mem_rd     <= id_ex_rd;
    end
  end

  // memory port, held until dhit.
  // a finished access stays off the port while the pipeline waits for ihit.
  assign dmemaddr  = ex_mem_result;
  assign dmemstore = ex_mem_store;
  assign dmemREN   = ex_mem_dren && !mem_done;
  assign dmemWEN   = ex_mem_dwen && !mem_done;

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      mem_done <= 1'b0;
    end else if (advance) begin
      mem_done <= 1'b0;
    end else if ((dmemREN || dmemWEN) && dhit) begin
      mem_done <= 1'b1;
    end
  end

  // load data from the dhit cycle, kept for a later advance.
  always_ff @(posedge CLK) begin
    if (dmemREN && dhit) begin
      mem_hold <= dmemload;
    end
  end

  // MEM/WB latch.
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      mem_wb_regwen <= 1'b0;
      mem_wb_halt   <= 1'b0;
    end else if (advance) begin
      mem_wb_regwen <= ex_mem_regwen;
      mem_wb_halt   <= ex_mem_halt;
    end
  end

  always_ff @(posedge CLK) begin
    if (advance) begin
      mem_wb_is_load <= ex_mem_dren;
      mem_wb_result  <= ex_mem_result;
      mem_wb_load    <= mem_done ? mem_hold : dmemload;
      mem_wb_rd      <= ex_mem_rd;
    end
  end

  // writeback; the write and the trace happen on the advancing edge only.
  assign wb_data = mem_wb_is_load ? mem_wb_load : mem_wb_result;
  assign wb_wen  = mem_wb_regwen && advance;
  assign wb_reg  = mem_wb_rd;

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      halt <= 1'b0;
    end else begin
      halt <= halt || mem_wb_halt;
    end
  end

  hazard_unit u_hu (
    .id_rs        (id_rs),
    .id_rt        (id_rt),
    .ex_dren      (id_ex_dren),
    .ex_rd        (id_ex_rd),
    .ex_regwen    (id_ex_regwen),
    .mem_rd       (ex_mem_rd),
    .mem_regwen   (ex_mem_regwen),
    .wb_rd        (mem_wb_rd),
    .wb_regwen    (mem_wb_regwen),
    .ex_rs        (id_ex_rs),
    .ex_rt        (id_ex_rt),
    .mem_pcsrc    (ex_mem_pcsrc),
    .mem_zero     (ex_mem_zero),
    .pc_en        (pc_en),
    .stall_id     (stall_id),
    .flush_ex     (flush_ex),
    .branch_taken (branch_taken),
    .fwd_a        (fwd_a),
    .fwd_b        (fwd_b)
  );

endmodule

/* hazard_unit.sv */
/*
  load-use stall, branch resolution and operand forwarding.
  branches and jumps are resolved from the EX/MEM latch.
  forwarding from EX/MEM wins over MEM/WB; register 0 is never forwarded.
*/
`timescale 1ns/100ps

module hazard_unit (
  input  cpu_types_pkg::regbits_t id_rs,
  input  cpu_types_pkg::regbits_t id_rt,
  input  logic                    ex_dren,
  input  cpu_types_pkg::regbits_t ex_rd,
  input  logic                    ex_regwen,
  input  cpu_types_pkg::regbits_t mem_rd,
  input  logic                    mem_regwen,
  input  cpu_types_pkg::regbits_t wb_rd,
  input  logic                    wb_regwen,
  input  cpu_types_pkg::regbits_t ex_rs,
  input  cpu_types_pkg::regbits_t ex_rt,
  input  dp_types_pkg::pcsrc_t    mem_pcsrc,
  input  logic                    mem_zero,
  output logic                    pc_en,
  output logic                    stall_id,
  output logic                    flush_ex,
  output logic                    branch_taken,
  output dp_types_pkg::fwdsel_t   fwd_a,
  output dp_types_pkg::fwdsel_t   fwd_b
);

  logic load_use;

  function automatic dp_types_pkg::fwdsel_t pick_fwd(input cpu_types_pkg::regbits_t src);
    dp_types_pkg::fwdsel_t sel;
    sel = dp_types_pkg::FWD_NONE;
    if (wb_regwen && wb_rd != '0 && wb_rd == src) sel = dp_types_pkg::FWD_WB;
    if (mem_regwen && mem_rd != '0 && mem_rd == src) sel = dp_types_pkg::FWD_MEM;
    return sel;
  endfunction

  // a load in EX whose result the decode stage needs.
  assign load_use = ex_dren && ex_regwen && (ex_rd != '0) &&
                    ((ex_rd == id_rs) || (ex_rd == id_rt));

  always_comb begin
    case (mem_pcsrc)
      dp_types_pkg::PCSRC_JUMP: branch_taken = 1'b1;
      dp_types_pkg::PCSRC_BEQ:  branch_taken = mem_zero;
      dp_types_pkg::PCSRC_BNE:  branch_taken = !mem_zero;
      default:                  branch_taken = 1'b0;
    endcase
  end

  assign pc_en    = !load_use || branch_taken;
  assign stall_id = load_use;
  assign flush_ex = load_use || branch_taken;

  always_comb begin
    fwd_a = pick_fwd(ex_rs);
    fwd_b = pick_fwd(ex_rt);
  end

endmodule

/* control_unit.sv */
/*
  instruction decode into datapath selects.
  unknown opcodes and functs become a no-op with no register or memory write.
*/
`timescale 1ns/100ps

module control_unit (
  input  cpu_types_pkg::opcode_t opcode,
  input  cpu_types_pkg::funct_t  funct,
  output dp_types_pkg::aluop_t   aluop,
  output dp_types_pkg::alusrc_t  alusrc,
  output dp_types_pkg::regsrc_t  regsrc,
  output dp_types_pkg::regdst_t  regdst,
  output dp_types_pkg::pcsrc_t   pcsrc,
  output logic                   regwen,
  output logic                   dren,
  output logic                   dwen,
  output logic                   extsel,
  output logic                   halt
);

  always_comb begin
    // no-op defaults.
    aluop  = dp_types_pkg::ALU_ADD;
    alusrc = dp_types_pkg::ALUSRC_REG;
    regsrc = dp_types_pkg::REGSRC_ALU;
    regdst = dp_types_pkg::REGDST_NONE;
    pcsrc  = dp_types_pkg::PCSRC_SEQ;
    regwen = 1'b0;
    dren   = 1'b0;
    dwen   = 1'b0;
    extsel = 1'b0;
    halt   = 1'b0;

    case (opcode)
      cpu_types_pkg::RTYPE: begin
        regdst = dp_types_pkg::REGDST_RD;
        regwen = 1'b1;
        case (funct)
          cpu_types_pkg::ADDU: aluop = dp_types_pkg::ALU_ADD;
          cpu_types_pkg::SUBU: aluop = dp_types_pkg::ALU_SUB;
          cpu_types_pkg::AND:  aluop = dp_types_pkg::ALU_AND;
          cpu_types_pkg::OR:   aluop = dp_types_pkg::ALU_OR;
          cpu_types_pkg::XOR:  aluop = dp_types_pkg::ALU_XOR;
          cpu_types_pkg::SLT:  aluop = dp_types_pkg::ALU_SLT;
          default: begin
            regdst = dp_types_pkg::REGDST_NONE;
            regwen = 1'b0;
          end
        endcase
      end
      cpu_types_pkg::ADDIU, cpu_types_pkg::SLTI,
      cpu_types_pkg::ANDI, cpu_types_pkg::ORI: begin
        alusrc = dp_types_pkg::ALUSRC_IMM;
        regdst = dp_types_pkg::REGDST_RT;
        regwen = 1'b1;
        extsel = (opcode == cpu_types_pkg::ADDIU) || (opcode == cpu_types_pkg::SLTI);
        if (opcode == cpu_types_pkg::SLTI) aluop = dp_types_pkg::ALU_SLT;
        if (opcode == cpu_types_pkg::ANDI) aluop = dp_types_pkg::ALU_AND;
        if (opcode == cpu_types_pkg::ORI) aluop = dp_types_pkg::ALU_OR;
      end
      cpu_types_pkg::LUI: begin
        regsrc = dp_types_pkg::REGSRC_LUI;
        regdst = dp_types_pkg::REGDST_RT;
        regwen = 1'b1;
      end
      cpu_types_pkg::LW: begin
        alusrc = dp_types_pkg::ALUSRC_IMM;
        regsrc = dp_types_pkg::REGSRC_MEM;
        regdst = dp_types_pkg::REGDST_RT;
        regwen = 1'b1;
        dren   = 1'b1;
        extsel = 1'b1;
      end
      cpu_types_pkg::SW: begin
        alusrc = dp_types_pkg::ALUSRC_IMM;
        dwen   = 1'b1;
        extsel = 1'b1;
      end
      cpu_types_pkg::BEQ, cpu_types_pkg::BNE: begin
        aluop  = dp_types_pkg::ALU_SUB;
        extsel = 1'b1;
        pcsrc  = (opcode == cpu_types_pkg::BEQ) ? dp_types_pkg::PCSRC_BEQ
                                                : dp_types_pkg::PCSRC_BNE;
      end
      cpu_types_pkg::J: pcsrc = dp_types_pkg::PCSRC_JUMP;
      cpu_types_pkg::JAL: begin
        pcsrc  = dp_types_pkg::PCSRC_JUMP;
        regsrc = dp_types_pkg::REGSRC_PC4;
        regdst = dp_types_pkg::REGDST_RA;
        regwen = 1'b1;
      end
      cpu_types_pkg::HALT: halt = 1'b1;
      default: ;
    endcase
  end

endmodule

/* alu.sv */
/*
  combinational ALU.
  SLT compares signed; add and subtract wrap without overflow detection.
*/
`timescale 1ns/100ps

module alu (
  input  dp_types_pkg::aluop_t aluop,
  input  cpu_types_pkg::word_t port_a,
  input  cpu_types_pkg::word_t port_b,
  output cpu_types_pkg::word_t port_o,
  output logic                 zero
);

  always_comb begin
    case (aluop)
      dp_types_pkg::ALU_ADD: port_o = port_a + port_b;
      dp_types_pkg::ALU_SUB: port_o = port_a - port_b;
      dp_types_pkg::ALU_AND: port_o = port_a & port_b;
      dp_types_pkg::ALU_OR:  port_o = port_a | port_b;
      dp_types_pkg::ALU_XOR: port_o = port_a ^ port_b;
      dp_types_pkg::ALU_SLT: begin
        port_o = cpu_types_pkg::word_t'($signed(port_a) < $signed(port_b));
      end
      default: port_o = port_a + port_b;
    endcase
  end

  // branches compare with SUB, so zero means equal.
  assign zero = (port_o == '0);

endmodule

/* register_file.sv */
/*
  32 x 32 register file, two combinational reads and one write port.
  a read of the register being written returns the new data.
  register 0 always reads zero.
*/
`timescale 1ns/100ps

module register_file (
  input  logic                    CLK,
  input  logic                    nRST,
  input  logic                    wen,
  input  cpu_types_pkg::regbits_t wsel,
  input  cpu_types_pkg::word_t    wdat,
  input  cpu_types_pkg::regbits_t rsel1,
  input  cpu_types_pkg::regbits_t rsel2,
  output cpu_types_pkg::word_t    rdat1,
  output cpu_types_pkg::word_t    rdat2
);

  cpu_types_pkg::word_t regs [cpu_types_pkg::REG_COUNT];

  function automatic cpu_types_pkg::word_t read_port(input cpu_types_pkg::regbits_t sel);
    cpu_types_pkg::word_t val;
    if (sel == '0) val = '0;
    else if (wen && wsel == sel) val = wdat;
    else val = regs[sel];
    return val;
  endfunction

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      for (int i = 0; i < cpu_types_pkg::REG_COUNT; i++) begin
        regs[i] <= '0;
      end
    end else if (wen && wsel != '0) begin
      regs[wsel] <= wdat;
    end
  end

  // write-through bypass for the decode stage.
  always_comb begin
    rdat1 = read_port(rsel1);
    rdat2 = read_port(rsel2);
  end

endmodule

/* dp_types_pkg.sv */
/*
  datapath control selects and forwarding encodings.
  depends on cpu_types_pkg for the word type, so compile that first.
*/
package dp_types_pkg;

  localparam cpu_types_pkg::word_t PC_INIT = '0;

  typedef enum logic [2:0] {
    ALU_ADD = 3'd0,
    ALU_SUB = 3'd1,
    ALU_AND = 3'd2,
    ALU_OR  = 3'd3,
    ALU_XOR = 3'd4,
    ALU_SLT = 3'd5
  } aluop_t;

  // writeback source.
  typedef enum logic [1:0] {REGSRC_ALU, REGSRC_MEM, REGSRC_LUI, REGSRC_PC4} regsrc_t;

  // destination register; RA is register 31.
  typedef enum logic [1:0] {REGDST_RD, REGDST_RT, REGDST_RA, REGDST_NONE} regdst_t;

  typedef enum logic {ALUSRC_REG, ALUSRC_IMM} alusrc_t;

  typedef enum logic [1:0] {PCSRC_SEQ, PCSRC_JUMP, PCSRC_BEQ, PCSRC_BNE} pcsrc_t;

  // operand source for the EX stage.
  typedef enum logic [1:0] {FWD_NONE, FWD_MEM, FWD_WB} fwdsel_t;

endpackage

/* cpu_types_pkg.sv */
/*
  instruction-set types for the MIPS subset core.
  only the opcodes and functs that the pipeline executes are enumerated;
  any other encoding decodes as a no-op.
*/
package cpu_types_pkg;

  localparam int WORD_W    = 32;
  localparam int REG_W     = 5;
  localparam int REG_COUNT = 32;
  localparam int OPCODE_W  = 6;
  localparam int FUNCT_W   = 6;
  localparam int IMM_W     = 16;
  localparam int ADDR_W    = 26;

  // lsb of each instruction field.
  localparam int OP_LSB = 26;
  localparam int RS_LSB = 21;
  localparam int RT_LSB = 16;
  localparam int RD_LSB = 11;

  typedef logic [WORD_W-1:0] word_t;
  typedef logic [REG_W-1:0]  regbits_t;

  typedef enum logic [OPCODE_W-1:0] {
    RTYPE = 6'h00,
    J     = 6'h02,
    JAL   = 6'h03,
    BEQ   = 6'h04,
    BNE   = 6'h05,
    ADDIU = 6'h09,
    SLTI  = 6'h0a,
    ANDI  = 6'h0c,
    ORI   = 6'h0d,
    LUI   = 6'h0f,
    LW    = 6'h23,
    SW    = 6'h2b,
    HALT  = 6'h3f
  } opcode_t;

  typedef enum logic [FUNCT_W-1:0] {
    ADDU = 6'h21,
    SUBU = 6'h23,
    AND  = 6'h24,
    OR   = 6'h25,
    XOR  = 6'h26,
    SLT  = 6'h2a
  } funct_t;

endpackage
